// ==== verilog.f ====
source/lcdBusPkg.sv
source/lcdCommandPkg.sv
source/lcdStepTable.sv
source/lcdOpSequencer.sv
source/lcdBusWriter.sv
source/screenController.sv
tests/screenControllerProperties.sv
tests/screenControllerTb.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module screenControllerTb \
  -f verilog.f \
  -o screenControllerSim

./obj_dir/screenControllerSim

// ==== tests/screenControllerTb.sv ====
`timescale 1ns/100ps

module screenControllerTb;

  // one bus byte with its dcx level on top
  typedef logic [8:0] pairList[$];

  localparam int strobeLength = lcdBusPkg::strobeLowCycles + lcdBusPkg::strobeHighCycles;
  // init, off, on, five pixels, on with a dropped request, one more pixel
  localparam int totalSteps = 15 + 4 + 4 + 5 * 13 + 4 + 13;
  localparam int shortWait = int'(lcdBusPkg::waitShort);
  localparam int longWait = int'(lcdBusPkg::waitLong);
  localparam int totalWaits = 4 * shortWait + 3 * longWait + 3 * (shortWait + longWait);
  localparam int timeoutCycles = (totalSteps + totalWaits) * strobeLength + 1000;

  logic clk;
  logic rst;
  logic request;
  lcdCommandPkg::opKind op;
  logic [lcdBusPkg::coordWidth-1:0] xBus;
  logic [lcdBusPkg::coordWidth-1:0] yBus;
  logic ack;
  logic csx;
  logic dcx;
  logic wrx;
  lcdBusPkg::busByte data;

  integer seed;
  int cycleCount;
  int ackCount;
  int acceptedCount;
  logic wrxLast;
  logic [8:0] gotPair;
  logic [8:0] wantPair;
  pairList expectedQ;
  pairList capturedQ;

  screenController DUT (
    .clk(clk),
    .rst(rst),
    .request(request),
    .op(op),
    .xBus(xBus),
    .yBus(yBus),
    .ack(ack),
    .csx(csx),
    .dcx(dcx),
    .wrx(wrx),
    .data(data)
  );

  bind screenController screenControllerProperties protocolChecks (
    .clk(clk),
    .rst(rst),
    .csx(csx),
    .dcx(dcx),
    .wrx(wrx),
    .data(data),
    .ack(ack)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic reportFailure(input string reason);
    $display("%s", reason);
    $display("** FAIL **");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      reportFailure($sformatf("error: %s is 0x%0h, expected 0x%0h", name, actual, expected));
    end
  endtask

  function automatic logic [8:0] commandByte(input lcdBusPkg::busByte b);
    return {1'b0, b};
  endfunction

  function automatic logic [8:0] parameterByte(input lcdBusPkg::busByte b);
    return {1'b1, b};
  endfunction

  // what the panel should see on the bus for one operation
  function automatic pairList expectedBytes(input lcdCommandPkg::opKind kind,
                                            input logic [31:0] x, input logic [31:0] y);
    pairList q;
    logic [15:0] color;
    int i;
    case (kind)
      lcdCommandPkg::opInit: begin
        q.push_back(commandByte(lcdCommandPkg::cmdSleepIn));
        q.push_back(commandByte(lcdCommandPkg::cmdSoftReset));
        q.push_back(commandByte(lcdCommandPkg::cmdSleepOut));
        q.push_back(commandByte(lcdCommandPkg::cmdPixelFormat));
        q.push_back(parameterByte(lcdCommandPkg::pixelFormat16));
        q.push_back(commandByte(lcdCommandPkg::cmdMemoryAccess));
        q.push_back(parameterByte(lcdCommandPkg::memoryAccessOrder));
        q.push_back(commandByte(lcdCommandPkg::cmdDisplayOn));
      end
      lcdCommandPkg::opDisplayOff: begin
        q.push_back(commandByte(lcdCommandPkg::cmdDisplayOff));
        q.push_back(commandByte(lcdCommandPkg::cmdSleepIn));
      end
      lcdCommandPkg::opDisplayOn: begin
        q.push_back(commandByte(lcdCommandPkg::cmdSleepOut));
        q.push_back(commandByte(lcdCommandPkg::cmdDisplayOn));
      end
      default: begin
        case (kind)
          lcdCommandPkg::opRed: color = lcdCommandPkg::colorRed;
          lcdCommandPkg::opGreen: color = lcdCommandPkg::colorGreen;
          lcdCommandPkg::opBlue: color = lcdCommandPkg::colorBlue;
          lcdCommandPkg::opBlack: color = lcdCommandPkg::colorBlack;
          default: color = lcdCommandPkg::colorWhite;
        endcase
        q.push_back(commandByte(lcdCommandPkg::cmdColumnAddr));
        for (i = 3; i >= 0; i--) q.push_back(parameterByte(x[8*i +: 8]));
        q.push_back(commandByte(lcdCommandPkg::cmdPageAddr));
        for (i = 3; i >= 0; i--) q.push_back(parameterByte(y[8*i +: 8]));
        q.push_back(commandByte(lcdCommandPkg::cmdMemoryWrite));
        q.push_back(parameterByte(color[15:8]));
        q.push_back(parameterByte(color[7:0]));
      end
    endcase
    return q;
  endfunction

  task automatic startOp(input lcdCommandPkg::opKind kind, input logic [31:0] x,
                         input logic [31:0] y);
    pairList bytes;
    bytes = expectedBytes(kind, x, y);
    foreach (bytes[k]) expectedQ.push_back(bytes[k]);
    acceptedCount++;
    @(negedge clk);
    request = 1'b1;
    op = kind;
    xBus = x;
    yBus = y;
    @(negedge clk);
    request = 1'b0;
  endtask

  task automatic waitForAck();
    logic csxBefore;
    do begin
      csxBefore = csx;
      @(negedge clk);
    end while (ack !== 1'b1);
    // frame must be closed a cycle before ack shows up
    checkValue("csx", csxBefore, 1);
  endtask

  task automatic idleCycles(input int n);
    repeat (n) begin
      @(negedge clk);
      checkValue("csx", csx, 1);
      checkValue("wrx", wrx, 1);
    end
    checkValue("ack count", ackCount, acceptedCount);
  endtask

  task automatic runOp(input lcdCommandPkg::opKind kind, input logic [31:0] x,
                       input logic [31:0] y);
    startOp(kind, x, y);
    waitForAck();
    idleCycles(20);
  endtask

  // record each byte on the rising edge of wrx
  always @(negedge clk) begin
    if (!rst && !csx && wrx && !wrxLast) capturedQ.push_back({dcx, data});
    wrxLast = wrx;
  end

  always @(posedge clk) begin
    while (capturedQ.size() > 0) begin
      gotPair = capturedQ.pop_front();
      if (expectedQ.size() == 0) begin
        reportFailure("a write strobe appeared when no byte was expected");
      end else begin
        wantPair = expectedQ.pop_front();
        checkValue("dcx", gotPair[8], wantPair[8]);
        checkValue("data", gotPair[7:0], wantPair[7:0]);
      end
    end
  end

  always @(posedge clk) begin
    if (ack === 1'b1) ackCount++;
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= timeoutCycles) begin
      reportFailure("timeout: the run did not finish within the cycle limit");
    end
  end

  initial begin
    int c;
    seed = 72;
    cycleCount = 0;
    ackCount = 0;
    acceptedCount = 0;
    wrxLast = 1'b1;
    request = 1'b0;
    op = lcdCommandPkg::opInit;
    xBus = '0;
    yBus = '0;
    rst = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    checkValue("csx", csx, 1);
    checkValue("wrx", wrx, 1);
    checkValue("dcx", dcx, 1);
    checkValue("data", data, 0);
    checkValue("ack", ack, 0);
    idleCycles(10);

    runOp(lcdCommandPkg::opInit, 0, 0);
    runOp(lcdCommandPkg::opDisplayOff, 0, 0);
    runOp(lcdCommandPkg::opDisplayOn, 0, 0);

    for (c = 3; c <= 7; c++) begin
      runOp(lcdCommandPkg::opKind'(c), $random(seed), $random(seed));
    end

    // second request lands mid-operation and has to be dropped
    startOp(lcdCommandPkg::opDisplayOn, 0, 0);
    repeat (10) @(negedge clk);
    checkValue("csx", csx, 0);
    request = 1'b1;
    op = lcdCommandPkg::opRed;
    xBus = $random(seed);
    yBus = $random(seed);
    @(negedge clk);
    request = 1'b0;
    waitForAck();
    idleCycles(40);

    runOp(lcdCommandPkg::opWhite, $random(seed), $random(seed));

    if (expectedQ.size() != 0) begin
      reportFailure("some expected bytes never appeared on the bus");
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

// ==== tests/screenControllerProperties.sv ====
`timescale 1ns/100ps

module screenControllerProperties (
  input logic clk,
  input logic rst,
  input logic csx,
  input logic dcx,
  input logic wrx,
  input lcdBusPkg::busByte data,
  input logic ack
);

  // a strobe only inside a selected frame
  property strobeInsideFrame;
    @(posedge clk) disable iff (rst) !wrx |-> !csx;
  endproperty

  // panel latches on the rising edge of wrx, so the bus holds while it is low
  property busHeldDuringStrobe;
    @(posedge clk) disable iff (rst)
      (!wrx && !$past(wrx)) |-> ($stable(data) && $stable(dcx));
  endproperty

  property ackSingleCycle;
    @(posedge clk) disable iff (rst) ack |=> !ack;
  endproperty

  strobeInsideFrameCheck: assert property (strobeInsideFrame)
    else $error("wrx went low while csx was high");

  busHeldDuringStrobeCheck: assert property (busHeldDuringStrobe)
    else $error("data or dcx changed while wrx was low");

  ackSingleCycleCheck: assert property (ackSingleCycle)
    else $error("ack stayed high for more than one cycle");

endmodule

// ==== source/screenController.sv ====
`timescale 1ns/100ps

module screenController (
  input logic clk,
  input logic rst,
  input logic request,
  input lcdCommandPkg::opKind op,
  input logic [lcdBusPkg::coordWidth-1:0] xBus,
  input logic [lcdBusPkg::coordWidth-1:0] yBus,
  output logic ack,
  output logic csx,
  output logic dcx,
  output logic wrx,
  output lcdBusPkg::busByte data
);

  logic [lcdBusPkg::stepIndexWidth-1:0] stepIndex;
  lcdCommandPkg::opKind curOp;
  logic [lcdBusPkg::coordWidth-1:0] curX;
  logic [lcdBusPkg::coordWidth-1:0] curY;
  lcdBusPkg::stepKind kind;
  lcdBusPkg::busByte stepByte;
  logic [lcdBusPkg::waitCountWidth-1:0] waitCount;
  logic lastStep;
  logic stepStart;
  logic stepDone;
  logic frameActive;

  lcdOpSequencer sequencer (
    .clk(clk),
    .rst(rst),
    .request(request),
    .op(op),
    .xBus(xBus),
    .yBus(yBus),
    .stepIndex(stepIndex),
    .curOp(curOp),
    .curX(curX),
    .curY(curY),
    .lastStep(lastStep),
    .stepDone(stepDone),
    .stepStart(stepStart),
    .frameActive(frameActive),
    .ack(ack)
  );

  lcdStepTable stepTable (
    .curOp(curOp),
    .curX(curX),
    .curY(curY),
    .stepIndex(stepIndex),
    .kind(kind),
    .stepByte(stepByte),
    .waitCount(waitCount),
    .lastStep(lastStep)
  );

  lcdBusWriter busWriter (
    .clk(clk),
    .rst(rst),
    .frameActive(frameActive),
    .stepStart(stepStart),
    .kind(kind),
    .stepByte(stepByte),
    .waitCount(waitCount),
    .stepDone(stepDone),
    .csx(csx),
    .dcx(dcx),
    .wrx(wrx),
    .data(data)
  );

endmodule

// ==== source/lcdBusWriter.sv ====
`timescale 1ns/100ps

module lcdBusWriter (
  input logic clk,
  input logic rst,
  input logic frameActive,
  input logic stepStart,
  input lcdBusPkg::stepKind kind,
  input lcdBusPkg::busByte stepByte,
  input logic [lcdBusPkg::waitCountWidth-1:0] waitCount,
  output logic stepDone,
  output logic csx,
  output logic dcx,
  output logic wrx,
  output lcdBusPkg::busByte data
);

  typedef enum logic [2:0] {
    wOff,
    wSetup,
    wReady,
    wLow,
    wHigh,
    wWait
  } writerState;

  writerState state;
  logic [lcdBusPkg::waitCountWidth-1:0] phaseCount;
  logic pending;
  lcdBusPkg::stepKind kindQ;
  lcdBusPkg::busByte byteQ;
  logic [lcdBusPkg::waitCountWidth-1:0] waitQ;

  // step arrives while the setup delay may still be running
  always_ff @(posedge clk) begin
    if (stepStart) begin
      kindQ <= kind;
      byteQ <= stepByte;
      waitQ <= waitCount;
    end
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state <= wOff;
      phaseCount <= '0;
      pending <= 1'b0;
      stepDone <= 1'b0;
      csx <= 1'b1;
      dcx <= 1'b1;
      wrx <= 1'b1;
      data <= '0;
    end else begin
      stepDone <= 1'b0;
      if (!frameActive) begin
        state <= wOff;
        pending <= 1'b0;
        csx <= 1'b1;
        dcx <= 1'b1;
        wrx <= 1'b1;
        data <= '0;
      end else begin
        case (state)
          wOff: begin
            csx <= 1'b0;
            phaseCount <= lcdBusPkg::waitCountWidth'(lcdBusPkg::setupCycles - 1);
            state <= wSetup;
          end
          wSetup: begin
            if (phaseCount == '0) state <= wReady;
            else phaseCount <= phaseCount - 1'b1;
          end
          wReady: begin
            if (pending) begin
              pending <= 1'b0;
              if (kindQ == lcdBusPkg::stepWait) begin
                phaseCount <= waitQ - 1'b1;
                state <= wWait;
              end else begin
                // dcx high marks a parameter byte
                dcx <= (kindQ == lcdBusPkg::stepParam);
                data <= byteQ;
                wrx <= 1'b0;
                phaseCount <= lcdBusPkg::waitCountWidth'(lcdBusPkg::strobeLowCycles - 1);
                state <= wLow;
              end
            end
          end
          wLow: begin
            if (phaseCount == '0) begin
              // panel latches data on this rising edge
              wrx <= 1'b1;
              phaseCount <= lcdBusPkg::waitCountWidth'(lcdBusPkg::strobeHighCycles - 1);
              state <= wHigh;
            end else begin
              phaseCount <= phaseCount - 1'b1;
            end
          end
          wHigh, wWait: begin
            if (phaseCount == '0) begin
              stepDone <= 1'b1;
              state <= wReady;
            end else begin
              phaseCount <= phaseCount - 1'b1;
            end
          end
          default: begin
            state <= wOff;
          end
        endcase
        if (stepStart) pending <= 1'b1;
      end
    end
  end

endmodule

// ==== source/lcdOpSequencer.sv ====
`timescale 1ns/100ps

module lcdOpSequencer (
  input logic clk,
  input logic rst,
  input logic request,
  input lcdCommandPkg::opKind op,
  input logic [lcdBusPkg::coordWidth-1:0] xBus,
  input logic [lcdBusPkg::coordWidth-1:0] yBus,
  output logic [lcdBusPkg::stepIndexWidth-1:0] stepIndex,
  output lcdCommandPkg::opKind curOp,
  output logic [lcdBusPkg::coordWidth-1:0] curX,
  output logic [lcdBusPkg::coordWidth-1:0] curY,
  input logic lastStep,
  input logic stepDone,
  output logic stepStart,
  output logic frameActive,
  output logic ack
);

  typedef enum logic [2:0] {
    sIdle,
    sIssue,
    sBusy,
    sClose,
    sAckWait
  } seqState;

  seqState state;

  // one cycle per step, the table answers for the current index
  assign stepStart = (state == sIssue);

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state <= sIdle;
      stepIndex <= '0;
      frameActive <= 1'b0;
      ack <= 1'b0;
    end else begin
      ack <= 1'b0;
      case (state)
        sIdle: begin
          // requests are only taken here, anything else is dropped
          if (request) begin
            stepIndex <= '0;
            frameActive <= 1'b1;
            state <= sIssue;
          end
        end
        sIssue: begin
          state <= sBusy;
        end
        sBusy: begin
          if (stepDone) begin
            if (lastStep) begin
              frameActive <= 1'b0;
              state <= sClose;
            end else begin
              stepIndex <= stepIndex + 1'b1;
              state <= sIssue;
            end
          end
        end
        sClose: begin
          // writer raises csx during this cycle
          state <= sAckWait;
        end
        sAckWait: begin
          ack <= 1'b1;
          state <= sIdle;
        end
        default: begin
          state <= sIdle;
        end
      endcase
    end
  end

  // operation and coordinates stay fixed for the whole operation
  always_ff @(posedge clk) begin
    if (state == sIdle && request) begin
      curOp <= op;
      curX <= xBus;
      curY <= yBus;
    end
  end

endmodule

// ==== source/lcdStepTable.sv ====
`timescale 1ns/100ps

module lcdStepTable (
  input lcdCommandPkg::opKind curOp,
  input logic [lcdBusPkg::coordWidth-1:0] curX,
  input logic [lcdBusPkg::coordWidth-1:0] curY,
  input logic [lcdBusPkg::stepIndexWidth-1:0] stepIndex,
  output lcdBusPkg::stepKind kind,
  output lcdBusPkg::busByte stepByte,
  output logic [lcdBusPkg::waitCountWidth-1:0] waitCount,
  output logic lastStep
);

  logic [15:0] pixelColor;
  logic [lcdBusPkg::stepWordWidth-1:0] stepWord;
  logic [lcdBusPkg::stepIndexWidth-1:0] lastIndex;

  function automatic logic [lcdBusPkg::stepWordWidth-1:0] cmdStep(input lcdBusPkg::busByte b);
    return {lcdBusPkg::stepCmd, b, {lcdBusPkg::waitCountWidth{1'b0}}};
  endfunction

  function automatic logic [lcdBusPkg::stepWordWidth-1:0] paramStep(input lcdBusPkg::busByte b);
    return {lcdBusPkg::stepParam, b, {lcdBusPkg::waitCountWidth{1'b0}}};
  endfunction

  function automatic logic [lcdBusPkg::stepWordWidth-1:0] waitStep(
    input logic [lcdBusPkg::waitCountWidth-1:0] w
  );
    return {lcdBusPkg::stepWait, {lcdBusPkg::dataWidth{1'b0}}, w};
  endfunction

  always_comb begin
    case (curOp)
      lcdCommandPkg::opRed: pixelColor = lcdCommandPkg::colorRed;
      lcdCommandPkg::opGreen: pixelColor = lcdCommandPkg::colorGreen;
      lcdCommandPkg::opBlue: pixelColor = lcdCommandPkg::colorBlue;
      lcdCommandPkg::opBlack: pixelColor = lcdCommandPkg::colorBlack;
      default: pixelColor = lcdCommandPkg::colorWhite;
    endcase
  end

  always_comb begin
    stepWord = waitStep(lcdBusPkg::waitShort);
    case (curOp)
      lcdCommandPkg::opInit: begin
        lastIndex = 4'd14;
        case (stepIndex)
          // let the supply settle before the first command
          4'd0: stepWord = waitStep(lcdBusPkg::waitShort);
          4'd1: stepWord = cmdStep(lcdCommandPkg::cmdSleepIn);
          4'd2: stepWord = waitStep(lcdBusPkg::waitLong);
          4'd3: stepWord = cmdStep(lcdCommandPkg::cmdSoftReset);
          4'd4: stepWord = waitStep(lcdBusPkg::waitLong);
          4'd5: stepWord = cmdStep(lcdCommandPkg::cmdSleepOut);
          4'd6: stepWord = waitStep(lcdBusPkg::waitLong);
          4'd7: stepWord = cmdStep(lcdCommandPkg::cmdPixelFormat);
          4'd8: stepWord = paramStep(lcdCommandPkg::pixelFormat16);
          4'd9: stepWord = waitStep(lcdBusPkg::waitShort);
          4'd10: stepWord = cmdStep(lcdCommandPkg::cmdMemoryAccess);
          4'd11: stepWord = paramStep(lcdCommandPkg::memoryAccessOrder);
          4'd12: stepWord = waitStep(lcdBusPkg::waitShort);
          4'd13: stepWord = cmdStep(lcdCommandPkg::cmdDisplayOn);
          default: stepWord = waitStep(lcdBusPkg::waitShort);
        endcase
      end
      lcdCommandPkg::opDisplayOff: begin
        lastIndex = 4'd3;
        case (stepIndex)
          4'd0: stepWord = cmdStep(lcdCommandPkg::cmdDisplayOff);
          4'd1: stepWord = waitStep(lcdBusPkg::waitShort);
          4'd2: stepWord = cmdStep(lcdCommandPkg::cmdSleepIn);
          default: stepWord = waitStep(lcdBusPkg::waitLong);
        endcase
      end
      lcdCommandPkg::opDisplayOn: begin
        lastIndex = 4'd3;
        case (stepIndex)
          4'd0: stepWord = cmdStep(lcdCommandPkg::cmdSleepOut);
          4'd1: stepWord = waitStep(lcdBusPkg::waitLong);
          4'd2: stepWord = cmdStep(lcdCommandPkg::cmdDisplayOn);
          default: stepWord = waitStep(lcdBusPkg::waitShort);
        endcase
      end
      default: begin
        // single pixel: column window, page window, then the colour
        lastIndex = 4'd12;
        case (stepIndex)
          4'd0: stepWord = cmdStep(lcdCommandPkg::cmdColumnAddr);
          4'd1: stepWord = paramStep(curX[31:24]);
          4'd2: stepWord = paramStep(curX[23:16]);
          4'd3: stepWord = paramStep(curX[15:8]);
          4'd4: stepWord = paramStep(curX[7:0]);
          4'd5: stepWord = cmdStep(lcdCommandPkg::cmdPageAddr);
          4'd6: stepWord = paramStep(curY[31:24]);
          4'd7: stepWord = paramStep(curY[23:16]);
          4'd8: stepWord = paramStep(curY[15:8]);
          4'd9: stepWord = paramStep(curY[7:0]);
          4'd10: stepWord = cmdStep(lcdCommandPkg::cmdMemoryWrite);
          4'd11: stepWord = paramStep(pixelColor[15:8]);
          4'd12: stepWord = paramStep(pixelColor[7:0]);
          default: stepWord = waitStep(lcdBusPkg::waitShort);
        endcase
      end
    endcase
  end

  assign kind = lcdBusPkg::stepKind'(stepWord[lcdBusPkg::stepWordWidth-1 -:
                                              lcdBusPkg::stepKindWidth]);
  assign stepByte = stepWord[lcdBusPkg::waitCountWidth +: lcdBusPkg::dataWidth];
  assign waitCount = stepWord[lcdBusPkg::waitCountWidth-1:0];
  // an index past the end also counts as last so a stray index cannot hang
  assign lastStep = (stepIndex >= lastIndex);

endmodule

// ==== source/lcdCommandPkg.sv ====
package lcdCommandPkg;

  // operations the controller can carry out on request
  typedef enum logic [2:0] {
    opInit,
    opDisplayOff,
    opDisplayOn,
    opRed,
    opGreen,
    opBlue,
    opBlack,
    opWhite
  } opKind;

  // window and memory access
  localparam logic [7:0] cmdColumnAddr = 8'h2A;
  localparam logic [7:0] cmdPageAddr = 8'h2B;
  localparam logic [7:0] cmdMemoryWrite = 8'h2C;

  // power and reset
  localparam logic [7:0] cmdSleepIn = 8'h10;
  localparam logic [7:0] cmdSleepOut = 8'h11;
  localparam logic [7:0] cmdSoftReset = 8'h01;

  // panel setup
  localparam logic [7:0] cmdPixelFormat = 8'h3A;
  localparam logic [7:0] cmdMemoryAccess = 8'h36;
  localparam logic [7:0] cmdDisplayOn = 8'h29;
  localparam logic [7:0] cmdDisplayOff = 8'h28;

  // 16 bits per pixel on both the RGB and MCU side
  localparam logic [7:0] pixelFormat16 = 8'h55;

  // row/column exchange with BGR order
  localparam logic [7:0] memoryAccessOrder = 8'hB8;

  // RGB565 pixel values, sent high byte first
  localparam logic [15:0] colorRed = 16'hF800;
  localparam logic [15:0] colorGreen = 16'h07E0;
  localparam logic [15:0] colorBlue = 16'h001F;
  localparam logic [15:0] colorBlack = 16'h0000;
  localparam logic [15:0] colorWhite = 16'hFFFF;

endpackage

// ==== source/lcdBusPkg.sv ====
package lcdBusPkg;

  // 8080 style parallel bus
  localparam int dataWidth = 8;
  typedef logic [dataWidth-1:0] busByte;

  localparam int coordWidth = 32;

  // what a single step does on the bus
  localparam int stepKindWidth = 2;
  typedef enum logic [stepKindWidth-1:0] {
    stepCmd,
    stepParam,
    stepWait
  } stepKind;

  // init is the longest operation
  localparam int maxSteps = 15;
  localparam int stepIndexWidth = $clog2(maxSteps);

  localparam int waitCountWidth = 16;

  // step table entry: kind, byte, wait length
  localparam int stepWordWidth = stepKindWidth + dataWidth + waitCountWidth;

  // every write strobe uses the same timing
  localparam int strobeLowCycles = 2;
  localparam int strobeHighCycles = 2;
  localparam int setupCycles = 2;

  // panel delays, scaled down from milliseconds
  localparam logic [waitCountWidth-1:0] waitShort = 16'd20;
  localparam logic [waitCountWidth-1:0] waitLong = 16'd60;

endpackage
